// ==== logic/l1d_pkg.sv ====
package l1d_pkg;

    // cpu byte address split into tag, index and offset
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;

    // direct mapped, one line per set
    localparam int NUM_SETS = 64;

    // line geometry
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_W         = 512;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // word number inside a line
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // miss handling states
    typedef enum logic [1:0]
    {
        S_IDLE       = 2'b00,
        S_COMPARE    = 2'b01,
        S_WRITE_BACK = 2'b10,
        S_ALLOCATE   = 2'b11
    } cache_state_e;

endpackage

// ==== logic/l1d_controller.sv ====
`timescale 1ns/1ps

module l1d_controller
    import l1d_pkg::*;
(
    input  logic   clk,
    input  logic   nrst,
    input  tag_t   tag,
    input  index_t index,
    input  logic   read,
    input  logic   write,
    input  logic   flush,
    input  logic   l2_ready,
    output logic   stall,
    output logic   refill,
    output logic   update,
    output logic   l2_read,
    output logic   l2_write,
    output tag_t   victim_tag
);

    cache_state_e state;
    cache_state_e next_state;

    // per set bookkeeping
    tag_t                tag_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] dirty;

    // registered lookup result
    logic hit;
    logic miss;

    // high in the idle cycle right after a completed access
    logic done;

    logic request;
    logic lookup_hit;
    logic alloc_done;

    assign request    = read || write;
    assign lookup_hit = valid[index] && (tag_arr[index] == tag);
    assign alloc_done = (state == S_ALLOCATE) && l2_ready;

    // state register
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                // the completing cycle still shows the finished request
                if (request && !done)
                    next_state = S_COMPARE;
            end
            S_COMPARE:
            begin
                if (hit)
                    next_state = S_IDLE;
                else if (miss && dirty[index])
                    next_state = S_WRITE_BACK;
                else if (miss)
                    next_state = S_ALLOCATE;
            end
            S_WRITE_BACK:
            begin
                if (l2_ready)
                    next_state = S_ALLOCATE;
            end
            S_ALLOCATE:
            begin
                if (l2_ready)
                    next_state = S_COMPARE;
            end
            default:
            begin
                next_state = S_IDLE;
            end
        endcase
    end

    // lookup in the first compare cycle, cleared everywhere else
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end
        else if ((state == S_COMPARE) && !hit && !miss)
        begin
            hit  <= lookup_hit;
            miss <= !lookup_hit;
        end
        else
        begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            done <= 1'b0;
        else
            done <= (state == S_COMPARE) && hit;
    end

    // flush drops everything, dirty data included
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if ((state == S_IDLE) && flush)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (alloc_done)
        begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end
        else if (update)
        begin
            dirty[index] <= 1'b1;
        end
    end

    // new tag lands with the refill
    always_ff @(posedge clk)
    begin
        if (alloc_done)
            tag_arr[index] <= tag;
    end

    assign victim_tag = tag_arr[index];

    // strobes decoded straight from the state
    assign stall    = (state != S_IDLE);
    assign update   = (state == S_COMPARE) && hit && write;
    assign refill   = alloc_done;
    assign l2_read  = (state == S_ALLOCATE);
    assign l2_write = (state == S_WRITE_BACK);

endmodule

// ==== logic/l1d_data_array.sv ====
`timescale 1ns/1ps

module l1d_data_array
    import l1d_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  index_t    index,
    input  word_sel_t word_sel,
    input  word_t     wdata,
    input  line_t     l2_rdata,
    input  logic      refill,
    input  logic      update,
    output word_t     rd_word,
    output line_t     line
);

    // one line per set
    line_t mem [NUM_SETS];

    line_t cur_line;
    line_t merged_line;

    assign cur_line = mem[index];

    // cpu word dropped into its slot, rest of the line kept
    always_comb
    begin
        merged_line = cur_line;
        merged_line[word_sel*WORD_W +: WORD_W] = wdata;
    end

    // writes held off while in reset
    always_ff @(posedge clk)
    begin
        if (nrst)
        begin
            if (refill)
                mem[index] <= l2_rdata;
            else if (update)
                mem[index] <= merged_line;
        end
    end

    // combinational read side
    assign rd_word = cur_line[word_sel*WORD_W +: WORD_W];

    // victim line for write-back
    assign line = cur_line;

endmodule

// ==== logic/l1d_cache_top.sv ====
`timescale 1ns/1ps

module l1d_cache_top
    import l1d_pkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    input  logic  read,
    input  logic  write,
    input  logic  flush,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata,
    output logic  stall,
    output logic  l2_read,
    output logic  l2_write,
    output addr_t l2_addr,
    output line_t l2_wdata,
    input  line_t l2_rdata,
    input  logic  l2_ready
);

    tag_t      cpu_tag;
    index_t    index;
    word_sel_t word_sel;

    tag_t      victim_tag;
    tag_t      l2_tag;
    logic      refill;
    logic      update;
    line_t     line;

    // tag | index | word | byte
    assign cpu_tag  = addr[ADDR_W-1 -: TAG_W];
    assign index    = addr[OFFSET_W +: INDEX_W];
    assign word_sel = addr[OFFSET_W-1 -: $bits(word_sel_t)];

    l1d_controller ctrl_i (
        .clk        (clk),
        .nrst       (nrst),
        .tag        (cpu_tag),
        .index      (index),
        .read       (read),
        .write      (write),
        .flush      (flush),
        .l2_ready   (l2_ready),
        .stall      (stall),
        .refill     (refill),
        .update     (update),
        .l2_read    (l2_read),
        .l2_write   (l2_write),
        .victim_tag (victim_tag)
    );

    l1d_data_array data_i (
        .clk      (clk),
        .nrst     (nrst),
        .index    (index),
        .word_sel (word_sel),
        .wdata    (wdata),
        .l2_rdata (l2_rdata),
        .refill   (refill),
        .update   (update),
        .rd_word  (rdata),
        .line     (line)
    );

    // write-back goes to the old owner of the set
    assign l2_tag   = l2_write ? victim_tag : cpu_tag;
    assign l2_addr  = {l2_tag, index, {OFFSET_W{1'b0}}};
    assign l2_wdata = line;

endmodule

// ==== testbench/l1d_cache_properties.sv ====
`timescale 1ns/1ps

module l1d_cache_properties
    import l1d_pkg::*;
(
    input logic         clk,
    input logic         nrst,
    input cache_state_e state,
    input logic         stall,
    input logic         refill,
    input logic         update,
    input logic         l2_read,
    input logic         l2_write,
    input logic         l2_ready
);

    // a pending l2 request stays put until ready
    l2_req_held: assert property (@(posedge clk) disable iff (!nrst)
        ((l2_read || l2_write) && !l2_ready) |=> $stable({l2_read, l2_write}))
        else $error("l2 request changed before l2_ready");

    update_ends_access: assert property (@(posedge clk) disable iff (!nrst)
        update |=> !stall)
        else $error("write hit did not end the access");

    // refill closes allocate and hands back to compare
    refill_to_compare: assert property (@(posedge clk) disable iff (!nrst)
        refill |=> ((state == S_COMPARE) && !l2_read))
        else $error("refill not followed by compare");

    idle_after_reset: assert property (@(posedge clk) $rose(nrst) |-> !stall)
        else $error("stall high in the first cycle after reset");

endmodule

bind l1d_controller l1d_cache_properties props_i (
    .clk      (clk),
    .nrst     (nrst),
    .state    (state),
    .stall    (stall),
    .refill   (refill),
    .update   (update),
    .l2_read  (l2_read),
    .l2_write (l2_write),
    .l2_ready (l2_ready)
);

// ==== testbench/l1d_cache_tb.sv ====
`timescale 1ns/1ps

module l1d_cache_tb
    import l1d_pkg::*;
();

    localparam int     CLK_PERIOD  = 20;
    localparam int     NUM_OPS     = 400;
    // two compare passes, write-back and allocate at the longest l2 delay, idle cycles
    localparam int     MISS_CYCLES = 24;
    localparam longint WATCHDOG_NS = longint'(CLK_PERIOD) * (10 + NUM_OPS * MISS_CYCLES + 200);

    logic  clk;
    logic  nrst;
    logic  read;
    logic  write;
    logic  flush;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  stall;
    logic  l2_read;
    logic  l2_write;
    addr_t l2_addr;
    line_t l2_wdata;
    line_t l2_rdata;
    logic  l2_ready;

    // l2 contents keyed by line address
    line_t l2_mem [addr_t];

    // l2 requests seen during one access
    bit    ev_write_q [$];
    addr_t ev_addr_q  [$];
    line_t ev_line_q  [$];

    // reference model: architectural words, written-back words, shadow tags
    word_t mdl_mem [addr_t];
    word_t mdl_l2  [addr_t];
    tag_t  sh_tag   [NUM_SETS];
    logic  sh_valid [NUM_SETS];
    logic  sh_dirty [NUM_SETS];

    tag_t   tag_pool   [4] = '{20'h00000, 20'h00001, 20'h3c5a7, 20'hfffff};
    index_t index_pool [8] = '{6'd0, 6'd1, 6'd2, 6'd5, 6'd17, 6'd32, 6'd47, 6'd63};

    l1d_cache_top dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_line(line_t got, line_t exp, string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    // untouched memory, every address gets its own value
    function automatic word_t fill_word(addr_t a);
        return (a ^ 32'h5a5a_c3c3) * 32'h9e37_79b1;
    endfunction

    function automatic word_t arch_word(addr_t a);
        return mdl_mem.exists(a) ? mdl_mem[a] : fill_word(a);
    endfunction

    function automatic line_t arch_line(addr_t base);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++)
            l[w*WORD_W +: WORD_W] = arch_word(base + addr_t'(4*w));
        return l;
    endfunction

    function automatic line_t l2_line(addr_t base);
        line_t l;
        if (l2_mem.exists(base))
            return l2_mem[base];
        for (int w = 0; w < WORDS_PER_LINE; w++)
            l[w*WORD_W +: WORD_W] = fill_word(base + addr_t'(4*w));
        return l;
    endfunction

    task automatic do_access(logic is_write, addr_t a, word_t wd);
        tag_t   t;
        index_t i;
        logic   hit;
        logic   evict;
        addr_t  victim;
        line_t  victim_line;
        int     cycles;
        logic   seen;

        t           = a[ADDR_W-1 -: TAG_W];
        i           = a[OFFSET_W +: INDEX_W];
        hit         = sh_valid[i] && (sh_tag[i] == t);
        evict       = !hit && sh_valid[i] && sh_dirty[i];
        victim      = {sh_tag[i], i, {OFFSET_W{1'b0}}};
        victim_line = arch_line(victim);
        ev_write_q.delete();
        ev_addr_q.delete();
        ev_line_q.delete();
        cycles = 0;
        seen   = 1'b0;

        @(posedge clk);
        read  <= !is_write;
        write <= is_write;
        addr  <= a;
        wdata <= wd;
        do
        begin
            @(negedge clk);
            if (stall)
            begin
                seen = 1'b1;
                cycles++;
            end
        end
        while (stall || !seen);

        if (!hit)
        begin
            if (evict)
                for (int w = 0; w < WORDS_PER_LINE; w++)
                    mdl_l2[victim + addr_t'(4*w)] = arch_word(victim + addr_t'(4*w));
            sh_tag[i]   = t;
            sh_valid[i] = 1'b1;
            sh_dirty[i] = 1'b0;
        end
        if (is_write)
        begin
            mdl_mem[a]  = wd;
            sh_dirty[i] = 1'b1;
        end
        else
            check_word(rdata, arch_word(a), "read data");

        if (hit && (cycles != 2))
            abort_run($sformatf("hit at %h kept stall high for %0d cycles", a, cycles));
        if (ev_write_q.size() != (hit ? 0 : (evict ? 2 : 1)))
            abort_run($sformatf("access at %h made %0d l2 requests", a, ev_write_q.size()));
        if (evict)
        begin
            if (!ev_write_q[0])
                abort_run($sformatf("dirty miss at %h did not write back first", a));
            check_addr(ev_addr_q[0], victim, "write-back address");
            check_line(ev_line_q[0], victim_line, "write-back data");
        end
        if (!hit)
        begin
            if (ev_write_q[$])
                abort_run($sformatf("miss at %h ended without an l2 read", a));
            check_addr(ev_addr_q[$], {t, i, {OFFSET_W{1'b0}}}, "refill address");
        end

        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
    endtask

    // dirty lines fall back to whatever l2 holds
    task automatic do_flush();
        addr_t wa;

        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int s = 0; s < NUM_SETS; s++)
        begin
            if (sh_valid[s] && sh_dirty[s])
                for (int w = 0; w < WORDS_PER_LINE; w++)
                begin
                    wa = {sh_tag[s], index_t'(s), {OFFSET_W{1'b0}}} + addr_t'(4*w);
                    if (mdl_l2.exists(wa))
                        mdl_mem[wa] = mdl_l2[wa];
                    else
                        mdl_mem.delete(wa);
                end
            sh_valid[s] = 1'b0;
            sh_dirty[s] = 1'b0;
        end
    endtask

    // l2 answers each request after 1 to 4 cycles
    initial
    begin : l2_model
        addr_t req_addr;
        logic  req_write;
        line_t req_line;
        int    delay;

        forever
        begin
            @(negedge clk);
            if (nrst && (l2_read || l2_write))
            begin
                req_addr  = l2_addr;
                req_write = l2_write;
                req_line  = l2_wdata;
                ev_write_q.push_back(req_write);
                ev_addr_q.push_back(req_addr);
                ev_line_q.push_back(req_line);
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge clk);
                if (req_write)
                    l2_mem[req_addr] = req_line;
                l2_ready <= 1'b1;
                l2_rdata <= l2_line(req_addr);
                @(posedge clk);
                l2_ready <= 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout: cache stopped responding after %0d ns", WATCHDOG_NS));
    end

    initial
    begin : main
        int    r;
        addr_t a;

        nrst     = 1'b0;
        read     = 1'b0;
        write    = 1'b0;
        flush    = 1'b0;
        addr     = '0;
        wdata    = '0;
        l2_rdata = '0;
        l2_ready = 1'b0;
        void'($urandom(33183));
        for (int s = 0; s < NUM_SETS; s++)
        begin
            sh_tag[s]   = '0;
            sh_valid[s] = 1'b0;
            sh_dirty[s] = 1'b0;
        end
        repeat (10) @(posedge clk);
        nrst <= 1'b1;

        for (int n = 0; n < NUM_OPS; n++)
        begin
            r = $urandom_range(99, 0);
            a = {tag_pool[$urandom_range(3, 0)], index_pool[$urandom_range(7, 0)],
                 word_sel_t'($urandom_range(15, 0)), 2'b00};
            if (r < 3)
                do_flush();
            else
                do_access(r < 50, a, $urandom());
        end
        repeat (5) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/l1d_pkg.sv
logic/l1d_controller.sv
logic/l1d_data_array.sv
logic/l1d_cache_top.sv
testbench/l1d_cache_properties.sv
testbench/l1d_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 \
    --top-module l1d_cache_tb \
    -Mdir "$BUILD_DIR" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vl1d_cache_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
